// File: src/cache_cfg.svh
//////////////////////////////////////////////////
// geometry of the data caches and timing of the
// shared word memory, included by the RTL
//////////////////////////////////////////////////
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry
`define DCACHE_SETS      8
`define DCACHE_WAYS      2
`define DCACHE_BLK_WORDS 2

// memory depth in words
`define MEM_WORDS 1024

// cycles dwait stays high before each word completes
`define MEM_WAIT 2

`endif

// File: src/cpu_types_pkg.sv
//////////////////////////////////////////////////
// shared types for the data caches, the memory
// bus and the cache state machine
//////////////////////////////////////////////////
`include "cache_cfg.svh"

package cpu_types_pkg;

	typedef logic [31:0] word_t;

	// byte address as seen by a data cache
	typedef struct packed {
		logic [25:0] tag;
		logic [2:0]  idx;
		logic        blkoff; // word within block
		logic [1:0]  bytoff;
	} dcachef_t;

	// one way of one set
	typedef struct packed {
		logic [25:0]                        tag;
		word_t [`DCACHE_BLK_WORDS-1:0] data;
		logic                               valid;
		logic                               dirty;
	} cache_block_t;

	typedef enum logic [3:0] {
		idle,
		writeback1, // victim word 0
		writeback2,
		fetch1,     // new block word 0
		fetch2,
		fetch_done,
		flush1,
		flush2,
		flushed     // sticky until reset
	} cache_state_t;

endpackage

// File: src/cache_mem_if.sv
//////////////////////////////////////////////////
// word bus between one data cache and the memory
// arbiter, one instance per cache
//////////////////////////////////////////////////
`timescale 1ns/100ps

interface cache_mem_if;
	import cpu_types_pkg::*;

	logic  dREN;   // held as a level
	logic  dWEN;
	word_t daddr;
	word_t dstore;
	word_t dload;  // valid while dwait low
	logic  dwait;

	modport cache (
		output dREN, dWEN, daddr, dstore,
		input  dload, dwait
	);

	modport arbiter (
		input  dREN, dWEN, daddr, dstore,
		output dload, dwait
	);

endinterface

// File: src/dcache.sv
//////////////////////////////////////////////////
// two-way set associative write-back data cache
// with LRU replacement and flush on halt, serving
// one processor data port over cache_mem_if
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cache_cfg.svh"

module dcache (
	input  logic                 CLK,
	input  logic                 nRST,
	input  logic                 dmemREN,
	input  logic                 dmemWEN,
	input  cpu_types_pkg::word_t dmemaddr,
	input  cpu_types_pkg::word_t dmemstore,
	input  logic                 halt,
	output cpu_types_pkg::word_t dmemload,
	output logic                 dhit,
	output logic                 flushed,
	cache_mem_if.cache           mif
);
	import cpu_types_pkg::*;

	cache_state_t state, next_state;

	cache_block_t blocks [`DCACHE_SETS][`DCACHE_WAYS];
	logic [`DCACHE_SETS-1:0] used; // last used way per set
	logic wset;                    // way being filled
	logic [3:0] fcnt;              // flush walk, {way, set}

	dcachef_t req;
	logic req_any;
	logic hit0, hit1, hit, hway;
	logic vway;
	cache_block_t hblk, vblk, fblk;
	logic [2:0] fset;
	logic fway;

	assign req = dcachef_t'(dmemaddr);
	assign req_any = dmemREN | dmemWEN;

	// tag compare on both ways of the indexed set
	assign hit0 = blocks[req.idx][0].valid && (blocks[req.idx][0].tag == req.tag);
	assign hit1 = blocks[req.idx][1].valid && (blocks[req.idx][1].tag == req.tag);
	assign hit = hit0 | hit1;
	assign hway = hit1;
	assign hblk = blocks[req.idx][hway];

	// victim: invalid way 0, invalid way 1, else the one not last used
	always_comb begin
		if (!blocks[req.idx][0].valid)
			vway = 1'b0;
		else if (!blocks[req.idx][1].valid)
			vway = 1'b1;
		else
			vway = ~used[req.idx];
	end

	assign vblk = blocks[req.idx][wset];

	assign fset = fcnt[2:0];
	assign fway = fcnt[3];
	assign fblk = blocks[fset][fway];

	assign flushed = (state == cpu_types_pkg::flushed);

	function automatic word_t blk_addr(input logic [25:0] t, input logic [2:0] i,
			input logic w);
		dcachef_t a;
		a = '{tag: t, idx: i, blkoff: w, bytoff: 2'b00};
		return word_t'(a);
	endfunction

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (halt)
					next_state = flush1;
				else if (req_any && !hit)
					next_state = (blocks[req.idx][vway].valid && blocks[req.idx][vway].dirty) ?
						writeback1 : fetch1;
			end
			writeback1: if (!mif.dwait) next_state = writeback2;
			writeback2: if (!mif.dwait) next_state = fetch1;
			fetch1:     if (!mif.dwait) next_state = fetch2;
			fetch2:     if (!mif.dwait) next_state = fetch_done;
			fetch_done: next_state = idle;
			flush1: begin
				if (fblk.valid && fblk.dirty) begin
					if (!mif.dwait)
						next_state = flush2;
				end else if (fcnt == 4'hf) begin
					next_state = cpu_types_pkg::flushed;
				end
			end
			flush2: begin
				if (!mif.dwait)
					next_state = (fcnt == 4'hf) ? cpu_types_pkg::flushed : flush1;
			end
			cpu_types_pkg::flushed: next_state = state;
			default: next_state = idle;
		endcase
	end

	// bus and processor outputs
	always_comb begin
		mif.dREN = 1'b0;
		mif.dWEN = 1'b0;
		mif.daddr = '0;
		mif.dstore = '0;
		dhit = 1'b0;
		dmemload = '0;
		case (state)
			idle: begin
				if (req_any && hit && !halt) begin // hit answered this cycle
					dhit = 1'b1;
					dmemload = hblk.data[req.blkoff];
				end
			end
			writeback1, writeback2: begin
				mif.dWEN = 1'b1;
				mif.daddr = blk_addr(vblk.tag, req.idx, state == writeback2);
				mif.dstore = vblk.data[state == writeback2];
			end
			fetch1, fetch2: begin
				mif.dREN = 1'b1;
				mif.daddr = blk_addr(req.tag, req.idx, state == fetch2);
			end
			fetch_done: begin
				dhit = 1'b1;
				dmemload = vblk.data[req.blkoff];
			end
			flush1: begin
				if (fblk.valid && fblk.dirty) begin // clean ways are skipped
					mif.dWEN = 1'b1;
					mif.daddr = blk_addr(fblk.tag, fset, 1'b0);
					mif.dstore = fblk.data[0];
				end
			end
			flush2: begin
				mif.dWEN = 1'b1;
				mif.daddr = blk_addr(fblk.tag, fset, 1'b1);
				mif.dstore = fblk.data[1];
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= idle;
			wset <= 1'b0;
			fcnt <= '0;
			used <= '0;
			for (int s = 0; s < `DCACHE_SETS; s++)
				for (int w = 0; w < `DCACHE_WAYS; w++)
					blocks[s][w] <= '0;
		end else begin
			state <= next_state;
			case (state)
				idle: begin
					if (!halt && req_any) begin
						if (hit) begin
							used[req.idx] <= hway;
							if (dmemWEN) begin
								blocks[req.idx][hway].data[req.blkoff] <= dmemstore;
								blocks[req.idx][hway].dirty <= 1'b1;
							end
						end else begin
							wset <= vway; // latched for the whole miss
						end
					end
				end
				fetch1: begin
					if (!mif.dwait)
						blocks[req.idx][wset].data[0] <= mif.dload;
				end
				fetch2: begin
					if (!mif.dwait) begin
						blocks[req.idx][wset].data[1] <= mif.dload;
						blocks[req.idx][wset].tag <= req.tag;
						blocks[req.idx][wset].valid <= 1'b1;
						blocks[req.idx][wset].dirty <= 1'b0;
					end
				end
				fetch_done: begin
					used[req.idx] <= wset;
					if (dmemWEN) begin // pending write lands on the new block
						blocks[req.idx][wset].data[req.blkoff] <= dmemstore;
						blocks[req.idx][wset].dirty <= 1'b1;
					end
				end
				flush1: begin
					if (!(fblk.valid && fblk.dirty) && fcnt != 4'hf)
						fcnt <= fcnt + 4'd1;
				end
				flush2: begin
					if (!mif.dwait) begin
						blocks[fset][fway].dirty <= 1'b0;
						if (fcnt != 4'hf)
							fcnt <= fcnt + 4'd1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// File: src/mem_arbiter.sv
//////////////////////////////////////////////////
// shares the word memory between two data caches,
// core 0 first, grant held for a whole transfer
//////////////////////////////////////////////////
`timescale 1ns/100ps

module mem_arbiter (
	input  logic                 CLK,
	input  logic                 nRST,
	cache_mem_if.arbiter         c0,
	cache_mem_if.arbiter         c1,
	output logic                 ren,
	output logic                 wen,
	output cpu_types_pkg::word_t addr,
	output cpu_types_pkg::word_t wdata,
	input  cpu_types_pkg::word_t rdata,
	input  logic                 mem_wait
);

	logic granted; // owner was requesting last cycle
	logic owner;
	logic req0, req1;
	logic own_req;
	logic sel;     // cache on the bus this cycle

	assign req0 = c0.dREN | c0.dWEN;
	assign req1 = c1.dREN | c1.dWEN;
	assign own_req = owner ? req1 : req0;

	// owner keeps the bus while it requests, else core 0 wins
	assign sel = (granted && own_req) ? owner : ~req0;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			granted <= 1'b0;
			owner <= 1'b0;
		end else begin
			granted <= sel ? req1 : req0;
			owner <= sel;
		end
	end

	// request path to memory
	always_comb begin
		if (sel) begin
			ren = c1.dREN;
			wen = c1.dWEN;
			addr = c1.daddr;
			wdata = c1.dstore;
		end else begin
			ren = c0.dREN;
			wen = c0.dWEN;
			addr = c0.daddr;
			wdata = c0.dstore;
		end
	end

	// the waiting cache just sees a stalled bus
	assign c0.dwait = sel ? 1'b1 : mem_wait;
	assign c1.dwait = sel ? mem_wait : 1'b1;
	assign c0.dload = sel ? '0 : rdata;
	assign c1.dload = sel ? rdata : '0;

endmodule

// File: src/data_ram.sv
//////////////////////////////////////////////////
// behavioural word memory, cleared on reset, with
// a fixed wait before each word completes
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cache_cfg.svh"

module data_ram (
	input  logic                 CLK,
	input  logic                 nRST,
	input  logic                 ren,
	input  logic                 wen,
	input  cpu_types_pkg::word_t addr,
	input  cpu_types_pkg::word_t wdata,
	output cpu_types_pkg::word_t rdata,
	output logic                 mem_wait
);
	import cpu_types_pkg::*;

	localparam int AW = $clog2(`MEM_WORDS);
	localparam int CW = $clog2(`MEM_WAIT + 2);

	word_t mem [`MEM_WORDS];
	logic [CW-1:0] cnt, cur_cnt;
	word_t last_addr;
	logic last_en;
	logic en, fresh, done;

	assign en = ren | wen;
	assign fresh = en && (!last_en || addr != last_addr); // new access restarts the count
	assign cur_cnt = fresh ? '0 : cnt;
	assign done = en && (cur_cnt == CW'(`MEM_WAIT));
	assign mem_wait = ~done;

	assign rdata = mem[addr[AW+1:2]];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			cnt <= '0;
			last_addr <= '0;
			last_en <= 1'b0;
			for (int i = 0; i < `MEM_WORDS; i++)
				mem[i] <= '0;
		end else begin
			last_addr <= addr;
			last_en <= en;
			cnt <= (en && !done) ? cur_cnt + 1'b1 : '0;
			if (wen && done) // write lands in the completing cycle
				mem[addr[AW+1:2]] <= wdata;
		end
	end

endmodule

// File: src/dual_dcache_top.sv
//////////////////////////////////////////////////
// two data caches sharing one word memory through
// the arbiter, plain processor ports per core
//////////////////////////////////////////////////
`timescale 1ns/100ps

module dual_dcache_top (
	input  logic                 CLK,
	input  logic                 nRST,
	// core 0
	input  logic                 dmemREN_0,
	input  logic                 dmemWEN_0,
	input  cpu_types_pkg::word_t dmemaddr_0,
	input  cpu_types_pkg::word_t dmemstore_0,
	output cpu_types_pkg::word_t dmemload_0,
	output logic                 dhit_0,
	input  logic                 halt_0,
	output logic                 flushed_0,
	// core 1
	input  logic                 dmemREN_1,
	input  logic                 dmemWEN_1,
	input  cpu_types_pkg::word_t dmemaddr_1,
	input  cpu_types_pkg::word_t dmemstore_1,
	output cpu_types_pkg::word_t dmemload_1,
	output logic                 dhit_1,
	input  logic                 halt_1,
	output logic                 flushed_1
);

	cache_mem_if mif0 ();
	cache_mem_if mif1 ();

	logic ren, wen, mem_wait;
	cpu_types_pkg::word_t addr, wdata, rdata;

	dcache core0 (
		.CLK(CLK), .nRST(nRST),
		.dmemREN(dmemREN_0), .dmemWEN(dmemWEN_0),
		.dmemaddr(dmemaddr_0), .dmemstore(dmemstore_0),
		.halt(halt_0),
		.dmemload(dmemload_0), .dhit(dhit_0), .flushed(flushed_0),
		.mif(mif0)
	);

	dcache core1 (
		.CLK(CLK), .nRST(nRST),
		.dmemREN(dmemREN_1), .dmemWEN(dmemWEN_1),
		.dmemaddr(dmemaddr_1), .dmemstore(dmemstore_1),
		.halt(halt_1),
		.dmemload(dmemload_1), .dhit(dhit_1), .flushed(flushed_1),
		.mif(mif1)
	);

	mem_arbiter arb0 (
		.CLK(CLK), .nRST(nRST),
		.c0(mif0), .c1(mif1),
		.ren(ren), .wen(wen), .addr(addr), .wdata(wdata),
		.rdata(rdata), .mem_wait(mem_wait)
	);

	data_ram ram0 (
		.CLK(CLK), .nRST(nRST),
		.ren(ren), .wen(wen), .addr(addr), .wdata(wdata),
		.rdata(rdata), .mem_wait(mem_wait)
	);

endmodule

// File: verif/tb_dual_dcache.sv
//////////////////////////////////////////////////
// testbench for the two-core data cache system,
// directed and random traffic against a shadow
// memory; top module tb_dual_dcache via vlog.f
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_dual_dcache;
	import cpu_types_pkg::*;

	localparam int MAX_CYCLES = 4000; // about 160 ops of well under 25 cycles each

	logic CLK;
	logic nRST;
	logic [1:0] ren, wen, halt;
	logic [1:0] dhit, fl;
	word_t addr [2];
	word_t store [2];
	word_t load [2];

	word_t shadow [word_t]; // last value written by either core
	integer seed;
	int cycles;
	logic [1:0] fl_seen;
	logic wb_seen;         // core 0 went through writeback1

	dual_dcache_top dut0 (
		.CLK(CLK), .nRST(nRST),
		.dmemREN_0(ren[0]), .dmemWEN_0(wen[0]),
		.dmemaddr_0(addr[0]), .dmemstore_0(store[0]),
		.dmemload_0(load[0]), .dhit_0(dhit[0]),
		.halt_0(halt[0]), .flushed_0(fl[0]),
		.dmemREN_1(ren[1]), .dmemWEN_1(wen[1]),
		.dmemaddr_1(addr[1]), .dmemstore_1(store[1]),
		.dmemload_1(load[1]), .dhit_1(dhit[1]),
		.halt_1(halt[1]), .flushed_1(fl[1])
	);

	always #5 CLK = ~CLK;

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		assert (act === exp) else begin
			$display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// cycle limit
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	// second word of a block transfer
	function automatic bit mid_block(input cache_state_t s);
		return s == writeback2 || s == fetch2 || s == flush2;
	endfunction

	// flushed stays high and block transfers never interleave
	always @(negedge CLK) begin
		if (nRST) begin
			for (int c = 0; c < 2; c++)
				if (fl_seen[c])
					check_bit($sformatf("flushed_%0d", c), 1'b1, fl[c]);
			fl_seen = fl_seen | fl;
			if (mid_block(dut0.core0.state)) // core 1 stalled meanwhile
				check_bit("mif1.dwait", 1'b1, dut0.mif1.dwait);
			if (mid_block(dut0.core1.state))
				check_bit("mif0.dwait", 1'b1, dut0.mif0.dwait);
			if (dut0.core0.state == writeback1)
				wb_seen = 1'b1;
		end
	end

	function automatic word_t expected(input word_t a);
		return shadow.exists(a) ? shadow[a] : '0; // memory resets to zero
	endfunction

	// one request held until dhit, then dropped for a cycle
	task automatic access(input int c, input logic wr, input word_t a, input word_t d,
			output word_t rd, output bit fast);
		int waited;
		waited = 0;
		@(posedge CLK);
		#1;
		ren[c] = !wr;
		wen[c] = wr;
		addr[c] = a;
		store[c] = d;
		@(negedge CLK);
		while (!dhit[c]) begin
			waited++;
			@(negedge CLK);
		end
		fast = (waited == 0);
		rd = load[c];
		@(posedge CLK);
		#1;
		ren[c] = 1'b0;
		wen[c] = 1'b0;
		@(negedge CLK);
		check_bit($sformatf("dhit_%0d after answer", c), 1'b0, dhit[c]); // one pulse only
	endtask

	task automatic write_word(input int c, input word_t a, input word_t d);
		word_t rd;
		bit f;
		access(c, 1'b1, a, d, rd, f);
		shadow[a] = d;
	endtask

	task automatic read_check(input int c, input word_t a, output bit fast);
		word_t rd;
		access(c, 1'b0, a, '0, rd, fast);
		check_word($sformatf("dmemload_%0d @%h", c, a), expected(a), rd);
	endtask

	task automatic random_traffic(input int c, input word_t base, input int n);
		word_t a, d;
		bit f;
		repeat (n) begin
			a = base + ($random(seed) & 32'h0000_00fc); // 4 tags per set
			d = $random(seed);
			if ($random(seed) & 1)
				write_word(c, a, d);
			else
				read_check(c, a, f);
		end
	endtask

	task automatic flush_core(input int c);
		@(posedge CLK);
		#1 halt[c] = 1'b1;
		@(negedge CLK);
		while (!fl[c])
			@(negedge CLK);
	endtask

	initial begin
		bit f;
		seed = 15967;
		cycles = 0;
		fl_seen = '0;
		wb_seen = 1'b0;
		CLK = 1'b0;
		nRST = 1'b0;
		ren = '0;
		wen = '0;
		halt = '0;
		for (int c = 0; c < 2; c++) begin
			addr[c] = '0;
			store[c] = '0;
		end
		repeat (10) @(posedge CLK);
		#1 nRST = 1'b1;

		// after reset
		@(negedge CLK);
		check_bit("dhit_0", 1'b0, dhit[0]);
		check_bit("dhit_1", 1'b0, dhit[1]);
		check_bit("flushed_0", 1'b0, fl[0]);
		check_bit("flushed_1", 1'b0, fl[1]);
		read_check(0, 32'h0000_03c0, f);
		read_check(1, 32'h0000_01f0, f);

		// three tags in set 0 force a dirty eviction
		write_word(0, 32'h0000_0000, 32'h1111_0000);
		write_word(0, 32'h0000_0040, 32'h2222_0004);
		write_word(0, 32'h0000_0080, 32'h3333_0008);
		read_check(0, 32'h0000_0080, f);
		check_bit("dhit_0 in request cycle", 1'b1, f);
		read_check(0, 32'h0000_0000, f);
		read_check(0, 32'h0000_0040, f);
		assert (wb_seen) else begin
			$display("core 0 never wrote back a dirty victim during the eviction test");
			abort_run();
		end

		// LRU order A, B, A, C keeps A
		read_check(0, 32'h0000_0300, f);
		read_check(0, 32'h0000_0340, f);
		read_check(0, 32'h0000_0300, f);
		check_bit("dhit_0 in request cycle", 1'b1, f);
		read_check(0, 32'h0000_0380, f);
		read_check(0, 32'h0000_0300, f);
		check_bit("dhit_0 in request cycle", 1'b1, f);
		read_check(0, 32'h0000_0340, f);
		check_bit("dhit_0 in request cycle", 1'b0, f); // B was the victim

		// overlapping traffic on separate ranges
		fork
			random_traffic(0, 32'h0000_0000, 40);
			random_traffic(1, 32'h0000_0100, 40);
		join

		// core 0 fills every way dirty and flushes, then core 1 reads it back
		for (int i = 0; i < 32; i++)
			write_word(0, 32'h0000_0200 + i * 4, $random(seed));
		flush_core(0);
		for (int i = 0; i < 32; i++)
			read_check(1, 32'h0000_0200 + i * 4, f);
		flush_core(1);

		repeat (3) @(negedge CLK);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+src
src/cpu_types_pkg.sv
src/cache_mem_if.sv
src/dcache.sv
src/mem_arbiter.sv
src/data_ram.sv
src/dual_dcache_top.sv
verif/tb_dual_dcache.sv
